// File: Makefile
TOP = irTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module irTop -f irTop.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f irTop.f -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "RESULT: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: irTop.f
src/irPkg.sv
src/irIfs.sv
src/irLatch.sv
src/dispatchRam.sv
src/irTest.sv
src/irTop.sv
sim/irTb.sv

// File: sim/irTb.sv
`timescale 1ns/10ps
`default_nettype none

module irTb;
  import irPkg::*;

  // Rough test length in cycles including the table fill
  localparam int testCycles = 900;
  localparam int maxCycles = testCycles * 3 + 300;

  logic CON, rstN, loadIr, mbXfer, diagLoad, loadDram, dramWrite, adCarry, diagRead;
  logic [0:35] ad;
  logic [0:12] cacheData;
  logic [0:1] diagData;
  logic [0:8] dramWaddr;
  logic [0:14] dramWdata;
  logic [7:8] magic;
  diagSel diagFunc;
  logic ioLegal, acEq0, testSatisfied, adEq0, ebusDriving;
  logic [0:2] norm;
  logic [0:5] ebusData;
  logic [0:12] ir;
  logic [0:3] ac;
  logic [0:2] dramA, dramB;
  logic [0:7] dramJ;

  int errors = 0;
  int checks = 0;
  int cycles = 0;
  logic [31:0] seed = 32'hc0c0_f95e;

  // Reference state kept by the testbench
  logic [0:14] model [0:511];
  logic [0:12] pending [$];
  logic [0:12] irM;
  logic [0:3] acM;
  logic enIoJrstM, enAcM;
  logic [0:8] lastAddr;
  logic [0:14] lastWord;
  logic [0:7] lastJ;

  irTop dut0 (.*);

  initial begin
    CON = 1'b0;
    forever #20 CON = ~CON;
  end

  function automatic logic [31:0] nextRand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic logic [0:8] dispAddr(input logic [0:12] w, input logic io);
    logic [0:2] mid;
    if (io && w[0:2] == 3'b111) begin
      mid = (w[3:6] == 4'b1111) ? 3'b111 : w[7:9];
      return {3'b111, mid, w[10:12]};
    end
    return w[0:8];
  endfunction

  // JRST carries the AC field in the low J bits
  function automatic logic [0:7] deliveredJ(input logic [0:12] w, input logic [0:14] word);
    if (w[0:8] == 9'o254) return {word[7:10], w[9:12]};
    return word[7:14];
  endfunction

  function automatic logic [0:2] normCode(input logic [0:35] v);
    int first;
    first = -1;
    for (int i = 35; i >= 0; i--) begin
      if (v[i]) first = i;
    end
    if (first < 0) return 3'd0;
    if (first == 0) return 3'd1;
    if (first <= 6) return 3'd2;
    if (first <= 10) return 3'(first - 4);
    return 3'd7;
  endfunction

  function automatic logic testCond(input logic [0:2] b, input logic [0:35] v,
                                    input logic c, input logic [7:8] mg);
    logic any;
    any = (b[1] & (v == '0)) | (b[2] & (v[0] ^ c) & mg[7]) | (b[2] & v[0] & mg[8])
          | (c & (mg[7] == mg[8]));
    return any ^ b[0];
  endfunction

  // Random word shifted right so every normalize code gets hit
  function automatic logic [0:35] sparseAd(input int k);
    logic [31:0] a;
    logic [31:0] b;
    logic [0:35] v;
    int sh;
    a = nextRand();
    b = nextRand();
    v = {a, b[3:0]};
    sh = int'(b[31:26]) % 37;
    return (k == 0) ? '0 : v >> sh;
  endfunction

  function automatic logic [0:5] expectedReadout(input diagSel sel, input logic [0:35] v,
                                                 input logic c, input logic [7:8] mg);
    case (sel)
      selNormAddrHi: return {normCode(v), lastAddr[0:2]};
      selAddrLo:     return lastAddr[3:8];
      selAc:         return {enIoJrstM, enAcM, acM};
      selAB:         return lastWord[0:5];
      selTestJhi:    return {testCond(lastWord[3:5], v, c, mg), irM[0:8] == 9'o254, lastJ[0:3]};
      selParJlo:     return {lastWord[6], ^{lastWord[0:6], lastJ}, lastJ[4:7]};
      selFlags:      return {v == '0, irM[3:6] == 4'b1111, irM[9:12] == 4'h0, c, v[0], v[35]};
      default:       return {mg[7], mg[8], v[12], v[18], v[24], v[30]};
    endcase
  endfunction

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic report(input string name, input int errStart);
    if (errors == errStart) $display("%s: ok", name);
    else $display("%s: %0d errors", name, errors - errStart);
  endtask

  task automatic setEnables(input logic io, input logic en);
    @(posedge CON);
    diagLoad <= 1'b1;
    diagData <= {io, en};
    @(posedge CON);
    diagLoad <= 1'b0;
    enIoJrstM = io;
    enAcM = en;
  endtask

  task automatic loadWord(input logic mb, input logic [0:35] adVal, input logic [0:12] cdVal);
    logic [0:12] w;
    w = mb ? adVal[0:12] : cdVal;
    @(posedge CON);
    loadIr <= 1'b1;
    mbXfer <= mb;
    ad <= adVal;
    cacheData <= cdVal;
    @(posedge CON);
    loadIr <= 1'b0;
    @(negedge CON);
    irM = w;
    acM = enAcM ? w[9:12] : 4'h0;
    check("ir", 64'(ir), 64'(irM));
    check("ac", 64'(ac), 64'(acM));
    check("ioLegal", 64'(ioLegal), 64'(w[3:6] == 4'b1111));
    check("acEq0", 64'(acEq0), 64'(w[9:12] == 4'h0));
  endtask

  task automatic fillTable();
    logic [31:0] r;
    for (int a = 0; a < 512; a++) begin
      r = nextRand();
      @(posedge CON);
      dramWrite <= 1'b1;
      dramWaddr <= 9'(a);
      dramWdata <= r[14:0];
      model[a] = r[14:0];
    end
    @(posedge CON);
    dramWrite <= 1'b0;
  endtask

  // Loads each queued word and strobes its lookup one cycle behind it
  task automatic runLookups();
    int n;
    logic [0:12] w;
    logic [0:8] addr;
    logic [0:14] word;
    n = pending.size();
    for (int c = 0; c < n + 4; c++) begin
      @(posedge CON);
      loadIr <= (c < n);
      mbXfer <= 1'b0;
      if (c < n) cacheData <= pending[c];
      loadDram <= (c >= 1 && c <= n);
      @(negedge CON);
      if (c >= 4) begin
        w = pending[c-4];
        addr = dispAddr(w, enIoJrstM);
        word = model[addr];
        check("dramA", 64'(dramA), 64'(word[0:2]));
        check("dramB", 64'(dramB), 64'(word[3:5]));
        check("dramJ", 64'(dramJ), 64'(deliveredJ(w, word)));
        irM = w;
        acM = enAcM ? w[9:12] : 4'h0;
        lastAddr = addr;
        lastWord = word;
        lastJ = deliveredJ(w, word);
      end
    end
    pending.delete();
  endtask

  task automatic readSel(input diagSel sel, input logic [0:5] exp);
    @(posedge CON);
    diagRead <= 1'b1;
    diagFunc <= sel;
    @(negedge CON);
    check("ebusDriving", 64'(ebusDriving), 64'(1'b1));
    check($sformatf("ebusData %s", sel.name()), 64'(ebusData), 64'(exp));
  endtask

  task automatic resetAndLoad();
    int errStart;
    logic [31:0] r;
    logic [31:0] r2;
    logic [0:12] w;
    errStart = errors;
    @(negedge CON);
    check("ir", 64'(ir), 64'(0));
    check("ac", 64'(ac), 64'(0));
    check("ebusDriving", 64'(ebusDriving), 64'(0));
    for (int i = 0; i < 8; i++) begin
      if (i == 4) setEnables(1'b0, 1'b1);
      r = nextRand();
      r2 = nextRand();
      w = r[12:0];
      if (i % 3 == 0) w[3:6] = 4'hf;
      if (i % 4 == 1) w[9:12] = 4'h0;
      // The unused source carries the inverted word
      if (i % 2 == 1) loadWord(1'b1, {w, r2[22:0]}, ~w);
      else loadWord(1'b0, {~w, r2[22:0]}, w);
    end
    report("reset and load", errStart);
  endtask

  task automatic dispatchLookup();
    int errStart;
    logic [31:0] r;
    errStart = errors;
    fillTable();
    for (int i = 0; i < 6; i++) begin
      r = nextRand();
      // One I/O class opcode while the I/O dispatch enable is clear
      if (i == 0) r[12:10] = 3'b111;
      pending.push_back(r[12:0]);
      runLookups();
    end
    for (int k = 0; k < 2; k++) begin
      for (int i = 0; i < 3; i++) begin
        r = nextRand();
        pending.push_back(r[12:0]);
      end
      runLookups();
    end
    report("dispatch lookup", errStart);
  endtask

  task automatic addressAndJrst();
    int errStart;
    logic [31:0] r;
    logic [0:12] w;
    logic [0:35] adVal;
    errStart = errors;
    setEnables(1'b1, 1'b1);
    for (int i = 0; i < 6; i++) begin
      r = nextRand();
      w = r[12:0];
      w[0:2] = 3'b111;
      if (i % 2 == 0) w[3:6] = 4'hf;
      pending.push_back(w);
      runLookups();
      adVal = sparseAd(i);
      @(posedge CON);
      ad <= adVal;
      readSel(selAddrLo, lastAddr[3:8]);
      readSel(selNormAddrHi, {normCode(adVal), lastAddr[0:2]});
    end
    for (int i = 0; i < 3; i++) begin
      r = nextRand();
      pending.push_back({9'o254, r[3:0]});
    end
    runLookups();
    report("address and jrst", errStart);
  endtask

  task automatic parityCheck();
    int errStart;
    logic [31:0] r;
    errStart = errors;
    for (int i = 0; i < 8; i++) begin
      r = nextRand();
      pending.push_back(r[12:0]);
      runLookups();
      readSel(selParJlo, {lastWord[6], ^{lastWord[0:6], lastJ}, lastJ[4:7]});
    end
    report("parity", errStart);
  endtask

  task automatic testConditions();
    int errStart;
    logic [31:0] r;
    logic [0:35] adVal;
    errStart = errors;
    for (int i = 0; i < 4; i++) begin
      r = nextRand();
      pending.push_back(r[12:0]);
      runLookups();
      for (int k = 0; k < 8; k++) begin
        adVal = sparseAd(k);
        r = nextRand();
        @(posedge CON);
        ad <= adVal;
        adCarry <= r[0];
        magic <= r[2:1];
        @(negedge CON);
        check("testSatisfied", 64'(testSatisfied),
              64'(testCond(lastWord[3:5], adVal, r[0], r[2:1])));
        check("adEq0", 64'(adEq0), 64'(adVal == '0));
        check("norm", 64'(norm), 64'(normCode(adVal)));
      end
    end
    report("test conditions", errStart);
  endtask

  task automatic readoutSelects();
    int errStart;
    logic [31:0] r;
    logic [0:35] adVal;
    errStart = errors;
    for (int k = 0; k < 2; k++) begin
      // Opposite enable patterns tell the two enable bits apart
      setEnables(k == 0, k != 0);
      r = nextRand();
      // Second round uses JRST so its flag reads back as one
      pending.push_back(k == 0 ? r[12:0] : {9'o254, r[3:0]});
      runLookups();
      adVal = sparseAd(k + 1);
      r = nextRand();
      @(posedge CON);
      ad <= adVal;
      adCarry <= r[0];
      magic <= r[2:1];
      for (int s = 0; s < 8; s++) begin
        readSel(diagSel'(s), expectedReadout(diagSel'(s), adVal, r[0], r[2:1]));
      end
      @(posedge CON);
      diagRead <= 1'b0;
      @(negedge CON);
      check("ebusDriving", 64'(ebusDriving), 64'(0));
      check("ebusData idle", 64'(ebusData), 64'(0));
    end
    report("readout selects", errStart);
  endtask

  initial begin
    rstN = 1'b0;
    loadIr = 1'b0;
    mbXfer = 1'b0;
    ad = '0;
    cacheData = '0;
    diagLoad = 1'b0;
    diagData = '0;
    loadDram = 1'b0;
    dramWrite = 1'b0;
    dramWaddr = '0;
    dramWdata = '0;
    adCarry = 1'b0;
    magic = '0;
    diagRead = 1'b0;
    diagFunc = selNormAddrHi;
    enIoJrstM = 1'b0;
    enAcM = 1'b0;
    repeat (5) @(posedge CON);
    rstN <= 1'b1;
    resetAndLoad();
    dispatchLookup();
    addressAndJrst();
    parityCheck();
    testConditions();
    readoutSelects();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Watchdog
  initial begin
    while (cycles < maxCycles) begin
      @(posedge CON);
      cycles++;
    end
    $display("Timeout: tests still running after %0d cycles", maxCycles);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/dispatchRam.sv
`timescale 1ns/10ps
`default_nettype none

module dispatchRam (
  input  logic CON,
  input  logic rstN,
  input  logic loadDram,
  input  logic dramWrite,
  input  logic [0:irPkg::dramAddrBits-1] dramWaddr,
  input  logic [0:irPkg::dramWidth-1] dramWdata,
  instrIf.snk instr,
  dispIf.src disp
);
  import irPkg::*;

  logic [0:dramWidth-1] mem [0:dramDepth-1];

  logic [0:dramAddrBits-1] addrNext;
  logic instr7xx;
  logic instr3thru6;
  logic [0:2] ioMid;

  // Stage 1, address and instruction copy
  logic [0:dramAddrBits-1] addrReg;
  logic v1;
  logic jrst1;
  logic [0:acWidth-1] ac1;

  // Stage 2, raw RAM word
  logic [0:dramWidth-1] wordReg;
  logic v2;
  logic jrst2;
  logic [0:acWidth-1] ac2;

  // Stage 3, delivered fields
  logic [0:aWidth-1] aReg;
  logic [0:bWidth-1] bReg;
  logic pReg;
  logic [0:jWidth-1] jReg;
  logic [0:jWidth-1] jNext;

  // I/O class opcodes get a compressed address in the top eighth
  assign instr7xx = (&instr.ir[0:2]) & instr.enIoJrst;
  assign instr3thru6 = &instr.ir[3:6];
  assign ioMid = instr.ir[7:9] | {3{instr3thru6}};
  assign addrNext = instr7xx ? {3'b111, ioMid, instr.ir[10:12]} : instr.ir[0:opWidth-1];

  // Diagnostic table load
  always_ff @(posedge CON) begin
    if (dramWrite) begin
      mem[dramWaddr] <= dramWdata;
    end
  end

  // JRST replaces the low J bits with AC
  assign jNext = jrst2 ? {wordReg[dramPBit+1:dramPBit+jWidth-acWidth], ac2}
                       : wordReg[dramPBit+1:dramWidth-1];

  always_ff @(posedge CON) begin
    if (!rstN) begin
      addrReg <= '0;
      v1 <= 1'b0;
      jrst1 <= 1'b0;
      ac1 <= '0;
      wordReg <= '0;
      v2 <= 1'b0;
      jrst2 <= 1'b0;
      ac2 <= '0;
      aReg <= '0;
      bReg <= '0;
      pReg <= 1'b0;
      jReg <= '0;
    end else begin
      v1 <= loadDram;
      v2 <= v1;
      if (loadDram) begin
        addrReg <= addrNext;
        jrst1 <= instr.jrst;
        ac1 <= instr.ir[opWidth:irWidth-1];
      end
      if (v1) begin
        wordReg <= mem[addrReg];
        jrst2 <= jrst1;
        ac2 <= ac1;
      end
      if (v2) begin
        aReg <= wordReg[0:aWidth-1];
        bReg <= wordReg[aWidth:dramPBit-1];
        pReg <= wordReg[dramPBit];
        jReg <= jNext;
      end
    end
  end

  assign disp.dramAddr = addrReg;
  assign disp.dramA = aReg;
  assign disp.dramB = bReg;
  assign disp.dramP = pReg;
  assign disp.dramJ = jReg;

  // Odd parity over the fields as delivered
  assign disp.parityOk = ^{aReg, bReg, pReg, jReg};

  // Table loads only happen with dispatch idle
  noWriteDuringLoad: assert property (@(posedge CON) disable iff (!rstN)
    !(dramWrite && loadDram));

  // Address must be resolved once the IR is out of reset
  addrKnown: assert property (@(posedge CON) disable iff (!rstN)
    !$isunknown(addrReg));

endmodule

`default_nettype wire

// File: src/irIfs.sv
`timescale 1ns/10ps
`default_nettype none

// Instruction state published by the IR latch
interface instrIf;
  import irPkg::*;

  logic [0:irWidth-1] ir;
  logic [0:acWidth-1] ac;
  logic jrst;
  logic enIoJrst;
  logic enAc;

  modport src (output ir, ac, jrst, enIoJrst, enAc);
  modport snk (input ir, ac, jrst, enIoJrst, enAc);
endinterface

// Registered dispatch fields and their address
interface dispIf;
  import irPkg::*;

  logic [0:aWidth-1] dramA;
  logic [0:bWidth-1] dramB;
  logic dramP;
  logic [0:jWidth-1] dramJ;
  logic [0:dramAddrBits-1] dramAddr;
  logic parityOk;

  modport src (output dramA, dramB, dramP, dramJ, dramAddr, parityOk);
  modport snk (input dramA, dramB, dramP, dramJ, dramAddr, parityOk);
endinterface

`default_nettype wire

// File: src/irLatch.sv
`timescale 1ns/10ps
`default_nettype none

module irLatch (
  input  logic CON,
  input  logic rstN,
  input  logic loadIr,
  input  logic mbXfer,
  input  logic [0:irPkg::adWidth-1] ad,
  input  logic [0:irPkg::irWidth-1] cacheData,
  input  logic diagLoad,
  input  logic [0:1] diagData,
  output logic ioLegal,
  output logic acEq0,
  instrIf.src instr
);
  import irPkg::*;

  logic [0:irWidth-1] irReg;
  logic [0:acWidth-1] acReg;
  logic enIoJrstReg;
  logic enAcReg;
  logic [0:irWidth-1] irNext;

  // Word source, memory buffer transfer or cache
  assign irNext = mbXfer ? ad[0:irWidth-1] : cacheData;

  always_ff @(posedge CON) begin
    if (!rstN) begin
      irReg <= '0;
      acReg <= '0;
    end else if (loadIr) begin
      irReg <= irNext;
      // AC only latched when enabled by diagnostics
      acReg <= enAcReg ? irNext[opWidth:irWidth-1] : '0;
    end
  end

  // Diagnostic enables
  always_ff @(posedge CON) begin
    if (!rstN) begin
      enIoJrstReg <= 1'b0;
      enAcReg <= 1'b0;
    end else if (diagLoad) begin
      enIoJrstReg <= diagData[0];
      enAcReg <= diagData[1];
    end
  end

  // Opcode decodes
  assign instr.jrst = irReg[0:opWidth-1] == opJrst;
  assign ioLegal = &irReg[3:6];
  assign acEq0 = irReg[opWidth:irWidth-1] == '0;

  assign instr.ir = irReg;
  assign instr.ac = acReg;
  assign instr.enIoJrst = enIoJrstReg;
  assign instr.enAc = enAcReg;

  // Instruction fetch and diagnostic load come from exclusive microcode steps
  loadExclusive: assert property (@(posedge CON) disable iff (!rstN)
    !(loadIr && diagLoad));

endmodule

`default_nettype wire

// File: src/irPkg.sv
`default_nettype none

package irPkg;

  // Instruction word is opcode followed by AC, bit 0 is the MSB
  localparam int opWidth = 9;
  localparam int acWidth = 4;
  localparam int irWidth = opWidth + acWidth;

  // Dispatch RAM geometry
  localparam int dramDepth = 512;
  localparam int dramAddrBits = $clog2(dramDepth);

  // Dispatch word layout is A, B, P, J
  localparam int aWidth = 3;
  localparam int bWidth = 3;
  localparam int jWidth = 8;
  localparam int dramPBit = aWidth + bWidth;
  localparam int dramWidth = dramPBit + 1 + jWidth;

  // Datapath and diagnostic bus widths
  localparam int adWidth = 36;
  localparam int ebusWidth = 6;

  // JRST opcode, octal 254
  localparam logic [0:opWidth-1] opJrst = 9'o254;

  // Diagnostic readout selects
  typedef enum logic [2:0] {
    selNormAddrHi,
    selAddrLo,
    selAc,
    selAB,
    selTestJhi,
    selParJlo,
    selFlags,
    selCarries
  } diagSel;

endpackage

`default_nettype wire

// File: src/irTest.sv
`timescale 1ns/10ps
`default_nettype none

module irTest (
  input  logic [0:irPkg::adWidth-1] ad,
  input  logic adCarry,
  input  logic [7:8] magic,
  input  logic diagRead,
  input  irPkg::diagSel diagFunc,
  input  logic ioLegal,
  input  logic acEq0,
  instrIf.snk instr,
  dispIf.snk disp,
  output logic testSatisfied,
  output logic adEq0,
  output logic [0:2] norm,
  output logic ebusDriving,
  output logic [0:irPkg::ebusWidth-1] ebusData
);
  import irPkg::*;

  logic aGtB;
  logic magicEq;

  assign adEq0 = ~|ad;
  assign aGtB = ad[0] ^ adCarry;
  assign magicEq = magic[7] == magic[8];

  // B bit 0 inverts the sense of the whole test
  assign testSatisfied = (|{disp.dramB[1] & adEq0,
                            disp.dramB[2] & aGtB & magic[7],
                            disp.dramB[2] & ad[0] & magic[8],
                            magicEq & adCarry}) ^ disp.dramB[0];

  // Normalize priority, leftmost one wins
  always_comb begin
    if (ad[0]) begin
      norm = 3'd1;
    end else if (|ad[1:6]) begin
      norm = 3'd2;
    end else if (ad[7]) begin
      norm = 3'd3;
    end else if (ad[8]) begin
      norm = 3'd4;
    end else if (ad[9]) begin
      norm = 3'd5;
    end else if (ad[10]) begin
      norm = 3'd6;
    end else if (|ad[11:adWidth-1]) begin
      norm = 3'd7;
    end else begin
      norm = 3'd0;
    end
  end

  assign ebusDriving = diagRead;

  // Diagnostic readout
  always_comb begin
    ebusData = '0;
    if (diagRead) begin
      case (diagFunc)
        selNormAddrHi: ebusData = {norm, disp.dramAddr[0:2]};
        selAddrLo:     ebusData = disp.dramAddr[3:8];
        selAc:         ebusData = {instr.enIoJrst, instr.enAc, instr.ac};
        selAB:         ebusData = {disp.dramA, disp.dramB};
        selTestJhi:    ebusData = {testSatisfied, instr.jrst, disp.dramJ[0:3]};
        selParJlo:     ebusData = {disp.dramP, disp.parityOk, disp.dramJ[4:7]};
        selFlags:      ebusData = {adEq0, ioLegal, acEq0, adCarry, ad[0], ad[adWidth-1]};
        selCarries:    ebusData = {magic[7], magic[8], ad[12], ad[18], ad[24], ad[30]};
        default:       ebusData = '0;
      endcase
    end
  end

  // Bus is shared, so an idle reader must present all zeros
  always_comb begin
    quietWhenIdle: assert final (ebusDriving || ebusData == '0);
  end

endmodule

`default_nettype wire

// File: src/irTop.sv
`timescale 1ns/10ps
`default_nettype none

module irTop (
  input  logic CON,
  input  logic rstN,
  input  logic loadIr,
  input  logic mbXfer,
  input  logic [0:irPkg::adWidth-1] ad,
  input  logic [0:irPkg::irWidth-1] cacheData,
  input  logic diagLoad,
  input  logic [0:1] diagData,
  input  logic loadDram,
  input  logic dramWrite,
  input  logic [0:irPkg::dramAddrBits-1] dramWaddr,
  input  logic [0:irPkg::dramWidth-1] dramWdata,
  input  logic adCarry,
  input  logic [7:8] magic,
  input  logic diagRead,
  input  irPkg::diagSel diagFunc,
  output logic ioLegal,
  output logic acEq0,
  output logic testSatisfied,
  output logic adEq0,
  output logic [0:2] norm,
  output logic ebusDriving,
  output logic [0:irPkg::ebusWidth-1] ebusData,
  output logic [0:irPkg::irWidth-1] ir,
  output logic [0:irPkg::acWidth-1] ac,
  output logic [0:irPkg::aWidth-1] dramA,
  output logic [0:irPkg::bWidth-1] dramB,
  output logic [0:irPkg::jWidth-1] dramJ
);

  instrIf instrBus ();
  dispIf dispBus ();

  irLatch irLatch0 (
    .CON(CON),
    .rstN(rstN),
    .loadIr(loadIr),
    .mbXfer(mbXfer),
    .ad(ad),
    .cacheData(cacheData),
    .diagLoad(diagLoad),
    .diagData(diagData),
    .ioLegal(ioLegal),
    .acEq0(acEq0),
    .instr(instrBus.src)
  );

  dispatchRam dispatchRam0 (
    .CON(CON),
    .rstN(rstN),
    .loadDram(loadDram),
    .dramWrite(dramWrite),
    .dramWaddr(dramWaddr),
    .dramWdata(dramWdata),
    .instr(instrBus.snk),
    .disp(dispBus.src)
  );

  irTest irTest0 (
    .ad(ad),
    .adCarry(adCarry),
    .magic(magic),
    .diagRead(diagRead),
    .diagFunc(diagFunc),
    .ioLegal(ioLegal),
    .acEq0(acEq0),
    .instr(instrBus.snk),
    .disp(dispBus.snk),
    .testSatisfied(testSatisfied),
    .adEq0(adEq0),
    .norm(norm),
    .ebusDriving(ebusDriving),
    .ebusData(ebusData)
  );

  // Observation ports
  assign ir = instrBus.ir;
  assign ac = instrBus.ac;
  assign dramA = dispBus.dramA;
  assign dramB = dispBus.dramB;
  assign dramJ = dispBus.dramJ;

endmodule

`default_nettype wire
